//--- logic/glb_ic_pkg.sv
package glb_ic_pkg;

  //////////////////////////////////////////////////////////////////////
  // event counts
  //////////////////////////////////////////////////////////////////////
  localparam int unsigned num_units       = 8;
  localparam int unsigned events_per_unit = 2;
  localparam int unsigned num_events      = num_units * events_per_unit;

  //////////////////////////////////////////////////////////////////////
  // register write data layout
  //////////////////////////////////////////////////////////////////////
  localparam int unsigned req_wdat_width = 22;
  localparam int unsigned wdat_lo_bits   = 10; // wdat[9:0] -> events 0..9
  localparam int unsigned wdat_hi_lsb    = 16; // wdat[21:16] -> events 10..15
  localparam int unsigned wdat_hi_bits   = num_events - wdat_lo_bits;

  //////////////////////////////////////////////////////////////////////
  // event types
  //////////////////////////////////////////////////////////////////////

  // one unit's done events, bit 0 is the unit's event 0
  typedef logic [events_per_unit-1:0] unit_event_t;

  // all events in global order
  typedef logic [num_events-1:0] event_vec_t;

  // unit order, unit u owns events 2u and 2u+1
  typedef enum logic [$clog2(num_units)-1:0] {
    unit_sdp      = 0,
    unit_cdp      = 1,
    unit_pdp      = 2,
    unit_bdma     = 3,
    unit_rubik    = 4,
    unit_cdma_dat = 5,
    unit_cdma_wt  = 6,
    unit_cacc     = 7
  } unit_idx;

endpackage

//--- logic/glb_ic_event_fanin.sv
`timescale 1ns/1ps

module glb_ic_event_fanin (
  input  logic                                  nvdla_core_clk,
  input  logic                                  nvdla_core_rstn,
  input  glb_ic_pkg::unit_event_t               done_pd [glb_ic_pkg::num_units],
  input  logic [glb_ic_pkg::req_wdat_width-1:0] req_wdat,
  input  logic                                  done_set_trigger,
  input  logic                                  done_clr_trigger,
  output glb_ic_pkg::unit_event_t               source_pd [glb_ic_pkg::num_units],
  output glb_ic_pkg::unit_event_t               set_pd [glb_ic_pkg::num_units],
  output glb_ic_pkg::unit_event_t               clr_pd [glb_ic_pkg::num_units]
);

  import glb_ic_pkg::*;

  event_vec_t wdat_events; // write data folded onto the 16 events

  //////////////////////////////////////////////////////////////////////
  // done pulse capture
  //////////////////////////////////////////////////////////////////////

  // one flop stage per event bit, pulses are not stretched
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      for (int u = 0; u < num_units; u++) begin
        source_pd[u] <= '0;
      end
    end else begin
      for (int u = 0; u < num_units; u++) begin
        source_pd[u] <= done_pd[u];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // register write decode
  //////////////////////////////////////////////////////////////////////

  // wdat[15:10] is a hole in the register map and is dropped here
  assign wdat_events = {req_wdat[wdat_hi_lsb +: wdat_hi_bits],
                        req_wdat[wdat_lo_bits-1:0]};

  // slice per unit, each trigger gates its own vector
  always_comb begin
    for (int u = 0; u < num_units; u++) begin
      if (done_set_trigger) begin
        set_pd[u] = wdat_events[u*events_per_unit +: events_per_unit];
      end else begin
        set_pd[u] = '0;
      end

      if (done_clr_trigger) begin
        clr_pd[u] = wdat_events[u*events_per_unit +: events_per_unit]; // w1c
      end else begin
        clr_pd[u] = '0;
      end
    end
  end

endmodule

//--- logic/glb_ic_unit_status.sv
`timescale 1ns/1ps

module glb_ic_unit_status (
  input  logic                    nvdla_core_clk,
  input  logic                    nvdla_core_rstn,
  input  glb_ic_pkg::unit_event_t source_pd,
  input  glb_ic_pkg::unit_event_t set_pd,
  input  glb_ic_pkg::unit_event_t clr_pd,
  input  glb_ic_pkg::unit_event_t done_mask,
  output glb_ic_pkg::unit_event_t done_status,
  output glb_ic_pkg::unit_event_t pending
);

  import glb_ic_pkg::*;

  unit_event_t status_nxt;

  //////////////////////////////////////////////////////////////////////
  // sticky status
  //////////////////////////////////////////////////////////////////////

  // set and hw event beat a clear on the same bit
  always_comb begin
    for (int b = 0; b < events_per_unit; b++) begin
      if (set_pd[b] || source_pd[b]) begin
        status_nxt[b] = 1'b1;
      end else if (clr_pd[b]) begin
        status_nxt[b] = 1'b0;
      end else begin
        status_nxt[b] = done_status[b]; // hold
      end
    end
  end

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      done_status <= '0;
    end else begin
      done_status <= status_nxt;
    end
  end

  // mask bit of 1 hides the event from the interrupt only,
  // status itself stays readable
  assign pending = done_status & ~done_mask;

endmodule

//--- logic/glb_ic_intr_merge.sv
`timescale 1ns/1ps

module glb_ic_intr_merge (
  input  logic                    nvdla_core_clk,
  input  logic                    nvdla_core_rstn,
  input  glb_ic_pkg::unit_event_t pending [glb_ic_pkg::num_units],
  output logic                    core_intr
);

  import glb_ic_pkg::*;

  logic any_pending;

  // wide OR over every unmasked status bit
  always_comb begin
    any_pending = 1'b0;
    for (int u = 0; u < num_units; u++) begin
      any_pending = any_pending | (|pending[u]);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // interrupt flop
  //////////////////////////////////////////////////////////////////////

  // level interrupt, drops once software clears or masks all sources
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      core_intr <= 1'b0;
    end else begin
      core_intr <= any_pending;
    end
  end

endmodule

//--- logic/glb_ic.sv
`timescale 1ns/1ps

module glb_ic (
  input  logic                                  nvdla_core_clk,
  input  logic                                  nvdla_core_rstn,
  // done pulses from the units
  input  glb_ic_pkg::unit_event_t               sdp2glb_done_intr_pd,
  input  glb_ic_pkg::unit_event_t               cdp2glb_done_intr_pd,
  input  glb_ic_pkg::unit_event_t               pdp2glb_done_intr_pd,
  input  glb_ic_pkg::unit_event_t               bdma2glb_done_intr_pd,
  input  glb_ic_pkg::unit_event_t               rubik2glb_done_intr_pd,
  input  glb_ic_pkg::unit_event_t               cdma_dat2glb_done_intr_pd,
  input  glb_ic_pkg::unit_event_t               cdma_wt2glb_done_intr_pd,
  input  glb_ic_pkg::unit_event_t               cacc2glb_done_intr_pd,
  // interrupt masks from the register file
  input  glb_ic_pkg::unit_event_t               sdp_done_mask,
  input  glb_ic_pkg::unit_event_t               cdp_done_mask,
  input  glb_ic_pkg::unit_event_t               pdp_done_mask,
  input  glb_ic_pkg::unit_event_t               bdma_done_mask,
  input  glb_ic_pkg::unit_event_t               rubik_done_mask,
  input  glb_ic_pkg::unit_event_t               cdma_dat_done_mask,
  input  glb_ic_pkg::unit_event_t               cdma_wt_done_mask,
  input  glb_ic_pkg::unit_event_t               cacc_done_mask,
  // status register writes
  input  logic [glb_ic_pkg::req_wdat_width-1:0] req_wdat,
  input  logic                                  done_set_trigger,
  input  logic                                  done_clr_trigger,
  // status readback
  output glb_ic_pkg::unit_event_t               sdp_done_status,
  output glb_ic_pkg::unit_event_t               cdp_done_status,
  output glb_ic_pkg::unit_event_t               pdp_done_status,
  output glb_ic_pkg::unit_event_t               bdma_done_status,
  output glb_ic_pkg::unit_event_t               rubik_done_status,
  output glb_ic_pkg::unit_event_t               cdma_dat_done_status,
  output glb_ic_pkg::unit_event_t               cdma_wt_done_status,
  output glb_ic_pkg::unit_event_t               cacc_done_status,
  output logic                                  core_intr
);

  import glb_ic_pkg::*;

  unit_event_t done_pd     [num_units]; // raw pulses by unit
  unit_event_t done_mask   [num_units];
  unit_event_t source_pd   [num_units]; // registered pulses
  unit_event_t set_pd      [num_units];
  unit_event_t clr_pd      [num_units];
  unit_event_t done_status [num_units];
  unit_event_t pending     [num_units]; // status & ~mask

  //////////////////////////////////////////////////////////////////////
  // pack loose unit ports
  //////////////////////////////////////////////////////////////////////

  assign done_pd[unit_sdp]      = sdp2glb_done_intr_pd;
  assign done_pd[unit_cdp]      = cdp2glb_done_intr_pd;
  assign done_pd[unit_pdp]      = pdp2glb_done_intr_pd;
  assign done_pd[unit_bdma]     = bdma2glb_done_intr_pd;
  assign done_pd[unit_rubik]    = rubik2glb_done_intr_pd;
  assign done_pd[unit_cdma_dat] = cdma_dat2glb_done_intr_pd;
  assign done_pd[unit_cdma_wt]  = cdma_wt2glb_done_intr_pd;
  assign done_pd[unit_cacc]     = cacc2glb_done_intr_pd;

  assign done_mask[unit_sdp]      = sdp_done_mask;
  assign done_mask[unit_cdp]      = cdp_done_mask;
  assign done_mask[unit_pdp]      = pdp_done_mask;
  assign done_mask[unit_bdma]     = bdma_done_mask;
  assign done_mask[unit_rubik]    = rubik_done_mask;
  assign done_mask[unit_cdma_dat] = cdma_dat_done_mask;
  assign done_mask[unit_cdma_wt]  = cdma_wt_done_mask;
  assign done_mask[unit_cacc]     = cacc_done_mask;

  //////////////////////////////////////////////////////////////////////
  // capture and write decode
  //////////////////////////////////////////////////////////////////////

  glb_ic_event_fanin u_fanin (
    .nvdla_core_clk   (nvdla_core_clk),
    .nvdla_core_rstn  (nvdla_core_rstn),
    .done_pd          (done_pd),
    .req_wdat         (req_wdat),
    .done_set_trigger (done_set_trigger),
    .done_clr_trigger (done_clr_trigger),
    .source_pd        (source_pd),
    .set_pd           (set_pd),
    .clr_pd           (clr_pd)
  );

  //////////////////////////////////////////////////////////////////////
  // per unit status
  //////////////////////////////////////////////////////////////////////

  for (genvar u = 0; u < num_units; u++) begin : g_unit
    glb_ic_unit_status u_status (
      .nvdla_core_clk  (nvdla_core_clk),
      .nvdla_core_rstn (nvdla_core_rstn),
      .source_pd       (source_pd[u]),
      .set_pd          (set_pd[u]),
      .clr_pd          (clr_pd[u]),
      .done_mask       (done_mask[u]),
      .done_status     (done_status[u]),
      .pending         (pending[u])
    );
  end

  //////////////////////////////////////////////////////////////////////
  // core interrupt
  //////////////////////////////////////////////////////////////////////

  glb_ic_intr_merge u_merge (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .pending         (pending),
    .core_intr       (core_intr)
  );

  // unpack status back to the register file
  assign sdp_done_status      = done_status[unit_sdp];
  assign cdp_done_status      = done_status[unit_cdp];
  assign pdp_done_status      = done_status[unit_pdp];
  assign bdma_done_status     = done_status[unit_bdma];
  assign rubik_done_status    = done_status[unit_rubik];
  assign cdma_dat_done_status = done_status[unit_cdma_dat];
  assign cdma_wt_done_status  = done_status[unit_cdma_wt];
  assign cacc_done_status     = done_status[unit_cacc];

endmodule

//--- testbench/glb_ic_tb.sv
`timescale 1ns/1ps

module glb_ic_tb;

  import glb_ic_pkg::*;

  localparam int          half_period    = 2;    // 4 ns clock
  localparam int          reset_cycles   = 4;
  localparam int          timeout_cycles = 2000; // about 4x the test length
  localparam int          random_cycles  = 300;
  localparam logic [31:0] seed           = 32'd40032;

  // expected state after each rising edge
  typedef struct packed {
    logic [num_events-1:0] src;    // registered done pulses
    logic [num_events-1:0] status; // sticky status bits
    logic                  intr;
  } model_t;

  logic                      nvdla_core_clk;
  logic                      nvdla_core_rstn;
  logic [num_events-1:0]     pulse_vec; // unit u drives bits 2u+1:2u
  logic [num_events-1:0]     mask_vec;
  logic [req_wdat_width-1:0] req_wdat;
  logic                      done_set_trigger;
  logic                      done_clr_trigger;
  wire  [num_events-1:0]     status_vec;
  wire                       core_intr;

  model_t      model;
  logic [31:0] rng_state;
  int          error_count;
  int          check_count;
  int          cycle_count;

  //////////////////////////////////////////////////////////////////////
  // DUT
  //////////////////////////////////////////////////////////////////////

  glb_ic DUT (
    .nvdla_core_clk            (nvdla_core_clk),
    .nvdla_core_rstn           (nvdla_core_rstn),
    .sdp2glb_done_intr_pd      (pulse_vec[1:0]),
    .cdp2glb_done_intr_pd      (pulse_vec[3:2]),
    .pdp2glb_done_intr_pd      (pulse_vec[5:4]),
    .bdma2glb_done_intr_pd     (pulse_vec[7:6]),
    .rubik2glb_done_intr_pd    (pulse_vec[9:8]),
    .cdma_dat2glb_done_intr_pd (pulse_vec[11:10]),
    .cdma_wt2glb_done_intr_pd  (pulse_vec[13:12]),
    .cacc2glb_done_intr_pd     (pulse_vec[15:14]),
    .sdp_done_mask             (mask_vec[1:0]),
    .cdp_done_mask             (mask_vec[3:2]),
    .pdp_done_mask             (mask_vec[5:4]),
    .bdma_done_mask            (mask_vec[7:6]),
    .rubik_done_mask           (mask_vec[9:8]),
    .cdma_dat_done_mask        (mask_vec[11:10]),
    .cdma_wt_done_mask         (mask_vec[13:12]),
    .cacc_done_mask            (mask_vec[15:14]),
    .req_wdat                  (req_wdat),
    .done_set_trigger          (done_set_trigger),
    .done_clr_trigger          (done_clr_trigger),
    .sdp_done_status           (status_vec[1:0]),
    .cdp_done_status           (status_vec[3:2]),
    .pdp_done_status           (status_vec[5:4]),
    .bdma_done_status          (status_vec[7:6]),
    .rubik_done_status         (status_vec[9:8]),
    .cdma_dat_done_status      (status_vec[11:10]),
    .cdma_wt_done_status       (status_vec[13:12]),
    .cacc_done_status          (status_vec[15:14]),
    .core_intr                 (core_intr)
  );

  always #half_period nvdla_core_clk = ~nvdla_core_clk;

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic string unit_label(input int u);
    case (u)
      0:       return "sdp";
      1:       return "cdp";
      2:       return "pdp";
      3:       return "bdma";
      4:       return "rubik";
      5:       return "cdma_dat";
      6:       return "cdma_wt";
      default: return "cacc";
    endcase
  endfunction

  // wdat[9:0] -> events 0..9, wdat[21:16] -> events 10..15
  function automatic logic [num_events-1:0] wdat_to_events(
    input logic [req_wdat_width-1:0] wdat
  );
    logic [num_events-1:0] ev;
    for (int e = 0; e < num_events; e++) begin
      if (e < wdat_lo_bits) begin
        ev[e] = wdat[e];
      end else begin
        ev[e] = wdat[wdat_hi_lsb + e - wdat_lo_bits];
      end
    end
    return ev;
  endfunction

  function automatic logic [req_wdat_width-1:0] event_to_wdat(input int e);
    logic [req_wdat_width-1:0] w;
    if (e < wdat_lo_bits) begin
      w = 22'h1 << e;
    end else begin
      w = 22'h1 << (e - wdat_lo_bits + wdat_hi_lsb);
    end
    return w;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  // one rising edge worth of state update
  function automatic model_t model_next(
    input model_t                    cur,
    input logic [num_events-1:0]     pulses,
    input logic [num_events-1:0]     masks,
    input logic [req_wdat_width-1:0] wdat,
    input logic                      set_trig,
    input logic                      clr_trig
  );
    model_t                nxt;
    logic [num_events-1:0] wev;
    wev = wdat_to_events(wdat);
    nxt.src = pulses;
    for (int e = 0; e < num_events; e++) begin
      if ((set_trig && wev[e]) || cur.src[e]) begin
        nxt.status[e] = 1'b1; // set beats clear
      end else if (clr_trig && wev[e]) begin
        nxt.status[e] = 1'b0;
      end else begin
        nxt.status[e] = cur.status[e];
      end
    end
    nxt.intr = |(cur.status & ~masks); // sees status before this edge
    return nxt;
  endfunction

  always @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      model <= '0;
    end else begin
      model <= model_next(model, pulse_vec, mask_vec, req_wdat,
                          done_set_trigger, done_clr_trigger);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // checking
  //////////////////////////////////////////////////////////////////////

  task automatic check_bus(input string sig, input logic [1:0] expected,
                           input logic [1:0] actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("[ERROR] t=%0d ns %s expected %b got %b", $time, sig, expected, actual);
    end
  endtask

  task automatic check_intr(input string sig, input logic expected, input logic actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("[ERROR] t=%0d ns %s expected %b got %b", $time, sig, expected, actual);
    end
  endtask

  task automatic expect_status(input logic [num_events-1:0] expected, input string what);
    for (int u = 0; u < num_units; u++) begin
      check_bus($sformatf("%s_done_status (%s)", unit_label(u), what),
                expected[2*u +: 2], status_vec[2*u +: 2]);
    end
  endtask

  task automatic expect_intr(input logic expected, input string what);
    check_intr($sformatf("core_intr (%s)", what), expected, core_intr);
  endtask

  // all outputs against the model once per cycle
  always @(negedge nvdla_core_clk) begin
    for (int u = 0; u < num_units; u++) begin
      check_bus({unit_label(u), "_done_status"}, model.status[2*u +: 2],
                status_vec[2*u +: 2]);
    end
    check_intr("core_intr", model.intr, core_intr);
  end

  always @(posedge nvdla_core_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("timeout: run did not finish within %0d cycles", timeout_cycles);
      $display("Checks failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus tasks
  //////////////////////////////////////////////////////////////////////

  task automatic write_done(input logic do_set, input logic do_clr,
                            input logic [req_wdat_width-1:0] wdat);
    @(negedge nvdla_core_clk);
    done_set_trigger = do_set;
    done_clr_trigger = do_clr;
    req_wdat         = wdat;
    @(negedge nvdla_core_clk);
    done_set_trigger = 1'b0;
    done_clr_trigger = 1'b0;
    req_wdat         = '0;
  endtask

  task automatic pulse_one_event(input int e);
    logic                  masked;
    logic [num_events-1:0] bit_e;
    masked = (e % 3 == 0); // every third event masked
    bit_e  = event_vec_t'(1) << e;
    @(negedge nvdla_core_clk);
    pulse_vec = bit_e;
    mask_vec  = masked ? bit_e : '0;
    @(negedge nvdla_core_clk);
    pulse_vec = '0;
    expect_status('0, "pulse in capture stage");
    @(negedge nvdla_core_clk);
    expect_status(bit_e, "pulse captured");
    expect_intr(1'b0, "one cycle behind status");
    @(negedge nvdla_core_clk);
    expect_status(bit_e, "status sticky");
    expect_intr(!masked, "single event");
    done_clr_trigger = 1'b1;
    req_wdat         = event_to_wdat(e);
    @(negedge nvdla_core_clk);
    done_clr_trigger = 1'b0;
    req_wdat         = '0;
    expect_status('0, "cleared by write");
    @(negedge nvdla_core_clk);
    expect_intr(1'b0, "after clear");
    mask_vec = '0;
  endtask

  task automatic apply_mask(input logic [num_events-1:0] m, input logic intr_exp);
    @(negedge nvdla_core_clk);
    mask_vec = m;
    @(negedge nvdla_core_clk);
    expect_intr(intr_exp, $sformatf("mask %h", m));
  endtask

  task automatic random_phase(input int cycles);
    repeat (cycles) begin
      @(negedge nvdla_core_clk);
      rng_state = xorshift32(rng_state);
      pulse_vec = rng_state[15:0] & rng_state[31:16]; // sparse pulses
      rng_state = xorshift32(rng_state);
      mask_vec  = rng_state[15:0];
      req_wdat  = rng_state[31:10];
      rng_state = xorshift32(rng_state);
      done_set_trigger = (rng_state[2:0] == 3'b000);
      done_clr_trigger = (rng_state[5:4] == 2'b00);
    end
    @(negedge nvdla_core_clk);
    pulse_vec        = '0;
    req_wdat         = '0;
    done_set_trigger = 1'b0;
    done_clr_trigger = 1'b0;
    repeat (3) @(negedge nvdla_core_clk); // drain the pipeline
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    nvdla_core_clk   = 1'b0;
    nvdla_core_rstn  = 1'b0;
    pulse_vec        = '0;
    mask_vec         = '0;
    req_wdat         = '0;
    done_set_trigger = 1'b0;
    done_clr_trigger = 1'b0;
    rng_state        = seed;
    error_count      = 0;
    check_count      = 0;
    cycle_count      = 0;

    repeat (reset_cycles) @(posedge nvdla_core_clk);
    @(negedge nvdla_core_clk);
    nvdla_core_rstn = 1'b1;
    expect_status('0, "after reset");
    expect_intr(1'b0, "after reset");

    for (int e = 0; e < num_events; e++) begin
      pulse_one_event(e);
    end

    // clear map skips wdat[15:10]
    write_done(1'b1, 1'b0, '1);
    expect_status('1, "set all");
    write_done(1'b0, 1'b1, 22'h00fc00);
    expect_status('1, "clear through unused bits");
    write_done(1'b0, 1'b1, 22'h2a0155);
    expect_status(16'h56aa, "partial clear");
    write_done(1'b0, 1'b1, '1);
    expect_status('0, "clear all");

    // set writes and collisions
    write_done(1'b1, 1'b0, 22'h040008); // events 3 and 12
    expect_status(16'h1008, "set write");
    write_done(1'b1, 1'b1, 22'h000020); // set and clear on event 5
    expect_status(16'h1028, "set beats clear");
    @(negedge nvdla_core_clk);
    pulse_vec = 16'h0080;
    @(negedge nvdla_core_clk);
    pulse_vec        = '0;
    done_clr_trigger = 1'b1;
    req_wdat         = 22'h000088; // event 7 arrives as 3 and 7 get cleared
    @(negedge nvdla_core_clk);
    done_clr_trigger = 1'b0;
    req_wdat         = '0;
    expect_status(16'h10a0, "pulse beats clear");
    write_done(1'b0, 1'b1, '1);
    expect_status('0, "clear all");

    // mask toggling with events 2 and 9 held
    @(negedge nvdla_core_clk);
    mask_vec = '1;
    write_done(1'b1, 1'b0, 22'h000204);
    expect_status(16'h0204, "held status");
    @(negedge nvdla_core_clk);
    expect_intr(1'b0, "all masked");
    apply_mask(16'hfffb, 1'b1);
    apply_mask(16'hbfff, 1'b0);
    apply_mask(16'hfdff, 1'b1);
    apply_mask(16'hffff, 1'b0);
    apply_mask(16'h0000, 1'b1);
    write_done(1'b0, 1'b1, '1);
    repeat (2) @(negedge nvdla_core_clk);

    random_phase(random_cycles);
    @(posedge nvdla_core_clk);

    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- glb_ic.f
logic/glb_ic_pkg.sv
logic/glb_ic_event_fanin.sv
logic/glb_ic_unit_status.sv
logic/glb_ic_intr_merge.sv
logic/glb_ic.sv
testbench/glb_ic_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

rm -f "$build_log" "$sim_log"

verilator --binary --timing --top-module glb_ic_tb -f glb_ic.f \
  -Mdir obj_dir -o glb_ic_sim > "$build_log" 2>&1 \
  && ./obj_dir/glb_ic_sim > "$sim_log" 2>&1 \
  || { echo "build or simulation run failed, see $build_log and $sim_log"; exit 1; }

cat "$sim_log"

grep -q "Checks failed" "$sim_log" \
  && { echo "simulation FAILED"; exit 1; } \
  || { echo "simulation passed"; exit 0; }
